/* verilog.f */
rtl/mem_pkg.sv
rtl/fetch_pkg.sv
rtl/icache.sv
rtl/predicted_npc.sv
rtl/fifo.sv
rtl/ifu.sv
test/ifu_properties.sv
test/ifu_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the ifu testbench with verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f verilog.f --top-module ifu_tb -o ifu_sim
out=$(./obj_dir/ifu_sim)
echo "$out"
if echo "$out" | grep -qF 'All tests passed!'; then
    exit 0
fi
exit 1

/* test/ifu_tb.sv */
module ifu_tb;
    import fetch_pkg::*;
    import mem_pkg::*;

    localparam int NUM_SETS     = 4;
    localparam int NUM_WAYS     = 2;
    localparam int FIFO_DEPTH   = 8;
    localparam int MEM_WORDS    = 1024;     // 4 KiB image, aliases above that
    localparam int RESET_CYCLES = 16;
    // about 95 dispatched entries and 40 block misses of up to 12 cycles each,
    // twice that under random ready, then a wide margin
    localparam int MAX_CYCLES   = 4000;

    logic         clk;
    logic         rst_n;
    addr_t        recovery_pc;
    logic         recovery_valid;
    logic         mem_req_valid;
    logic         mem_req_ready;
    mem_req_t     mem_req;
    logic         mem_resp_valid;
    mem_resp_t    mem_resp;
    logic         dispatch_ready;
    logic         instr_valid;
    ififo_entry_t instr_to_dispatch;

    instr_t prog [MEM_WORDS];
    addr_t  req_log [$];        // accepted block requests in order
    bit     rand_ready;         // dispatch ready toggles at random
    int     cycles = 0;
    int     checks = 0;
    int     mismatches = 0;
    int     failures = 0;

    ifu #(
        .NUM_SETS   (NUM_SETS),
        .NUM_WAYS   (NUM_WAYS),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_ifu (
        .clk               (clk),
        .rst_n             (rst_n),
        .recovery_pc       (recovery_pc),
        .recovery_valid    (recovery_valid),
        .mem_req_valid     (mem_req_valid),
        .mem_req_ready     (mem_req_ready),
        .mem_req           (mem_req),
        .mem_resp_valid    (mem_resp_valid),
        .mem_resp          (mem_resp),
        .dispatch_ready    (dispatch_ready),
        .instr_valid       (instr_valid),
        .instr_to_dispatch (instr_to_dispatch)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > MAX_CYCLES) begin
            failures++;
            $display("run stopped after %0d cycles without finishing the tests", MAX_CYCLES);
            $display("checks %0d, mismatches %0d, other errors %0d",
                     checks, mismatches, failures);
            $display("Test failures found");
            $finish;
        end
    end

    function automatic instr_t word_at(addr_t a);
        return prog[a[11:2]];
    endfunction

    // low word sits at the lower address
    function automatic block_t block_at(addr_t a);
        addr_t base;
        base = {a[31:3], 3'b000};
        return {word_at(base + 32'd4), word_at(base)};
    endfunction

    function automatic instr_t enc_jal(int off);
        logic [20:0] imm;
        imm = 21'(off);
        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd0, OPC_JAL};  // rd x0
    endfunction

    function automatic instr_t enc_branch(logic [2:0] funct3, int off);
        logic [12:0] imm;
        imm = 13'(off);
        return {imm[12], imm[10:5], 5'd0, 5'd0, funct3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    // static rule: backward branch taken, forward not, jal taken, rest pc + 4
    function automatic ififo_entry_t ref_entry(addr_t pc);
        instr_t       ins;
        int           off;
        ififo_entry_t e;
        ins              = word_at(pc);
        e.instr          = ins;
        e.pc             = pc;
        e.is_cond_br     = 1'b0;
        e.br_dir_pred    = 1'b0;
        e.br_target_pred = pc + 32'd4;
        case (ins[6:0])
            OPC_BRANCH: begin
                e.is_cond_br = 1'b1;
                off = int'($signed({ins[31], ins[7], ins[30:25], ins[11:8], 1'b0}));
                if (off < 0) begin
                    e.br_dir_pred    = 1'b1;
                    e.br_target_pred = pc + addr_t'(off);
                end
            end
            OPC_JAL: begin
                off = int'($signed({ins[31], ins[19:12], ins[20], ins[30:21], 1'b0}));
                e.br_target_pred = pc + addr_t'(off);
            end
            default: ;
        endcase
        return e;
    endfunction

    function automatic ififo_entry_t make_entry(addr_t at, logic br, logic dir, addr_t tgt);
        return '{instr: word_at(at), pc: at, is_cond_br: br, br_dir_pred: dir,
                 br_target_pred: tgt};
    endfunction

    function automatic int count_in_range(addr_t lo, addr_t hi);
        int n;
        n = 0;
        foreach (req_log[i])
            if (req_log[i] >= lo && req_log[i] < hi)
                n++;
        return n;
    endfunction

    task automatic place(addr_t a, instr_t ins);
        prog[a[11:2]] = ins;
    endtask

    task automatic load_program();
        for (int i = 0; i < MEM_WORDS; i++)
            prog[i] = {25'(i), 7'b001_0011};           // addi filler, fields from word index
        place(32'h040, enc_jal(0));                     // straight line parks here
        place(32'h100, enc_jal(32'h20));
        place(32'h108, enc_jal(32'h78));
        place(32'h120, enc_branch(3'b001, 32'h40));     // forward bne
        place(32'h124, enc_branch(3'b000, -28));        // backward beq to 0x108
        place(32'h180, enc_jal(0));
        place(32'h20c, enc_branch(3'b000, -12));        // two block loop
        place(32'h300, enc_jal(32'h20));                // 0x300, 0x320, 0x340 all set 0
        place(32'h304, enc_jal(0));
        place(32'h320, enc_jal(32'h20));
        place(32'h340, enc_jal(-60));                   // back into the evicted block
        place(32'h4a0, enc_jal(0));
        place(32'h504, enc_jal(28));
        place(32'h520, enc_branch(3'b001, -28));        // backward bne, loops
    endtask

    task automatic check_entry(string what, ififo_entry_t got, ififo_entry_t exp);
        checks++;
        if (got !== exp) begin
            mismatches++;
            $display("MISMATCH at %0t: %s got %h (pc %h) expected %h (pc %h)",
                     $time, what, got, got.pc, exp, exp.pc);
        end
    endtask

    task automatic check_count(string what, int got, int exp);
        checks++;
        if (got !== exp) begin
            mismatches++;
            $display("MISMATCH at %0t: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    // block memory: accept after 0-3 cycles, answer 2-6 cycles later
    initial begin : responder
        addr_t       blk_addr;
        int unsigned delay;
        mem_req_ready  = 1'b0;
        mem_resp_valid = 1'b0;
        mem_resp       = '0;
        forever begin
            @(negedge clk);
            if (rst_n && mem_req_valid) begin
                delay = $urandom_range(3, 0);
                repeat (delay) @(negedge clk);
                blk_addr      = mem_req.addr;
                mem_req_ready = 1'b1;
                @(negedge clk);                  // taken on the edge in between
                mem_req_ready = 1'b0;
                req_log.push_back(blk_addr);
                delay = $urandom_range(6, 2);
                repeat (delay - 1) @(negedge clk);
                mem_resp.data  = block_at(blk_addr);
                mem_resp_valid = 1'b1;
                @(negedge clk);
                mem_resp_valid = 1'b0;
            end
        end
    end

    // returns the entry that transfers on the next rising edge
    task automatic take_entry(output ififo_entry_t e);
        bit done;
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            dispatch_ready = rand_ready ? 1'($urandom_range(1, 0)) : 1'b1;
            if (instr_valid && dispatch_ready) begin
                e    = instr_to_dispatch;
                done = 1'b1;
            end
        end
    endtask

    task automatic release_dispatch();
        @(negedge clk);                          // lets the last transfer happen
        dispatch_ready = 1'b0;
    endtask

    task automatic follow_stream(addr_t start, int n);
        addr_t        pc;
        ififo_entry_t got;
        ififo_entry_t exp;
        pc = start;
        for (int i = 0; i < n; i++) begin
            take_entry(got);
            exp = ref_entry(pc);
            check_entry("instr_to_dispatch", got, exp);
            pc = exp.br_target_pred;
        end
        release_dispatch();
    endtask

    task automatic redirect(addr_t target);
        @(negedge clk);
        dispatch_ready = 1'b0;
        recovery_valid = 1'b1;
        recovery_pc    = target;
        @(negedge clk);
        recovery_valid = 1'b0;
        check_count("instr_valid after flush", int'(instr_valid), 0);
    endtask

    task automatic test_straight_line();
        check_count("instr_valid out of reset", int'(instr_valid), 0);
        follow_stream(RESET_PC, 18);
        check_count("block requests 0x000-0x047", count_in_range(32'h0, 32'h48), 9);
    endtask

    task automatic test_prediction();
        ififo_entry_t exp_q [$];
        ififo_entry_t got;
        redirect(32'h100);
        exp_q.push_back(make_entry(32'h100, 1'b0, 1'b0, 32'h120));  // jal
        exp_q.push_back(make_entry(32'h120, 1'b1, 1'b0, 32'h124));  // forward, falls through
        exp_q.push_back(make_entry(32'h124, 1'b1, 1'b1, 32'h108));  // backward, taken
        exp_q.push_back(make_entry(32'h108, 1'b0, 1'b0, 32'h180));
        exp_q.push_back(make_entry(32'h180, 1'b0, 1'b0, 32'h180));
        exp_q.push_back(make_entry(32'h180, 1'b0, 1'b0, 32'h180));
        foreach (exp_q[i]) begin
            take_entry(got);
            check_entry("instr_to_dispatch", got, exp_q[i]);
        end
        release_dispatch();
    endtask

    task automatic test_cache_reuse();
        redirect(32'h200);
        follow_stream(32'h200, 12);              // three turns of the loop
        check_count("block requests 0x200-0x20f", count_in_range(32'h200, 32'h210), 2);
    endtask

    task automatic test_eviction();
        addr_t seen [$];
        addr_t exp_blocks [4];
        redirect(32'h300);
        follow_stream(32'h300, 5);
        foreach (req_log[i])
            if (req_log[i] >= 32'h300 && req_log[i] < 32'h348)
                seen.push_back(req_log[i]);
        exp_blocks = '{32'h300, 32'h320, 32'h340, 32'h300};   // A evicted by C
        check_count("block requests 0x300-0x347", seen.size(), 4);
        foreach (exp_blocks[i])
            if (i < seen.size())
                check_count("mem_req.addr", int'(seen[i]), int'(exp_blocks[i]));
    endtask

    task automatic test_back_pressure();
        redirect(32'h400);
        repeat (30) @(negedge clk);
        check_count("instr_valid while held", int'(instr_valid), 1);
        rand_ready = 1'b1;
        follow_stream(32'h400, 42);
        rand_ready = 1'b0;
        check_count("block requests 0x400-0x4a7", count_in_range(32'h400, 32'h4a8), 21);
    endtask

    task automatic test_recovery();
        do
            @(negedge clk);
        while (!instr_valid);                    // fifo holds parked entries
        redirect(32'h500);
        follow_stream(32'h500, 10);
    endtask

    initial begin
        void'($urandom(32'h3385));
        rst_n          = 1'b0;
        recovery_pc    = '0;
        recovery_valid = 1'b0;
        dispatch_ready = 1'b0;
        rand_ready     = 1'b0;
        load_program();
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        test_straight_line();
        test_prediction();
        test_cache_reuse();
        test_eviction();
        test_back_pressure();
        test_recovery();
        $display("checks %0d, mismatches %0d, other errors %0d", checks, mismatches, failures);
        if (mismatches == 0 && failures == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

/* test/ifu_properties.sv */
// protocol checks on the fetch unit ports, bound into ifu
module ifu_properties (
    input logic                    clk,
    input logic                    rst_n,
    input logic                    mem_req_valid,
    input logic                    mem_req_ready,
    input mem_pkg::mem_req_t       mem_req,
    input logic                    instr_valid,
    input logic                    dispatch_ready,
    input fetch_pkg::ififo_entry_t instr_to_dispatch
);

    // one reset edge clears the miss fsm and the fifo count
    quiet_in_reset: assert property (@(posedge clk)
        !rst_n && $past(!rst_n) |-> !mem_req_valid && !instr_valid)
        else $error("mem_req_valid or instr_valid high while in reset");

    // request held until memory takes it
    req_held: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req))
        else $error("mem_req dropped or changed before mem_req_ready");

    deq_known: assert property (@(posedge clk) disable iff (!rst_n)
        instr_valid && dispatch_ready |-> !$isunknown(instr_to_dispatch))
        else $error("instr_to_dispatch has unknown bits on a dispatch transfer");

endmodule

bind ifu ifu_properties u_ifu_properties (.*);

/* rtl/ifu.sv */
// instruction fetch unit
// pc mux -> icache (sync read) -> half-block select -> static predictor -> instruction fifo
module ifu #(
    parameter int NUM_SETS   = mem_pkg::DEFAULT_NUM_SETS,
    parameter int NUM_WAYS   = mem_pkg::DEFAULT_NUM_WAYS,
    parameter int FIFO_DEPTH = 8
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  fetch_pkg::addr_t        recovery_pc,
    input  logic                    recovery_valid,
    output logic                    mem_req_valid,
    input  logic                    mem_req_ready,
    output mem_pkg::mem_req_t       mem_req,
    input  logic                    mem_resp_valid,
    input  mem_pkg::mem_resp_t      mem_resp,
    input  logic                    dispatch_ready,
    output logic                    instr_valid,
    output fetch_pkg::ififo_entry_t instr_to_dispatch
);
    import fetch_pkg::*;
    import mem_pkg::*;

    addr_t        pc_q;         // pc the icache outputs belong to
    addr_t        npc_mux;      // feeds both the pc register and the icache
    addr_t        pred_npc;
    block_t       ic_block;
    logic         ic_hit;
    instr_t       instr_sel;
    logic         is_cond_br;
    logic         br_dir_pred;
    logic         enq_valid;
    logic         enq_ready;
    logic         stall;
    ififo_entry_t enq_entry;

    // miss, or a hit the fifo has no room for
    assign stall = !ic_hit || !enq_ready;

    // priority: recovery, then hold, then prediction
    always_comb begin
        if (recovery_valid)
            npc_mux = recovery_pc;
        else if (stall)
            npc_mux = pc_q;                     // refetch same pc
        else
            npc_mux = pred_npc;
    end

    always_ff @(posedge clk) begin
        if (!rst_n)
            pc_q <= RESET_PC;
        else
            pc_q <= npc_mux;
    end

    icache #(
        .NUM_SETS (NUM_SETS),
        .NUM_WAYS (NUM_WAYS)
    ) u_icache (
        .clk            (clk),
        .rst_n          (rst_n),
        .rd_addr        (npc_mux),              // lines up with pc_q next cycle
        .mem_req_ready  (mem_req_ready),
        .mem_resp_valid (mem_resp_valid),
        .mem_resp       (mem_resp),
        .hit            (ic_hit),
        .rd_block       (ic_block),
        .mem_req_valid  (mem_req_valid),
        .mem_req        (mem_req)
    );

    // pc bit 2 picks the upper word
    assign instr_sel = pc_q[2] ? ic_block[BLOCK_BITS-1 -: INSTR_BITS]
                               : ic_block[INSTR_BITS-1:0];

    predicted_npc u_pred_npc (
        .instr       (instr_sel),
        .pc          (pc_q),
        .is_cond_br  (is_cond_br),
        .br_dir_pred (br_dir_pred),
        .next_pc     (pred_npc)
    );

    assign enq_entry = '{
        instr:          instr_sel,
        pc:             pc_q,
        is_cond_br:     is_cond_br,
        br_dir_pred:    br_dir_pred,
        br_target_pred: pred_npc
    };

    // wrong-path entry dropped on recovery
    assign enq_valid = ic_hit && !recovery_valid;

    fifo #(
        .entry_t (ififo_entry_t),
        .DEPTH   (FIFO_DEPTH)
    ) u_ififo (
        .clk       (clk),
        .rst_n     (rst_n),
        .flush     (recovery_valid),
        .enq_valid (enq_valid),
        .enq_ready (enq_ready),
        .enq_data  (enq_entry),
        .deq_valid (instr_valid),
        .deq_ready (dispatch_ready),
        .deq_data  (instr_to_dispatch)
    );

endmodule

/* rtl/fifo.sv */
// generic synchronous fifo
// valid/ready both sides, flush wins over enq and deq
module fifo #(
    parameter type entry_t = logic [31:0],
    parameter int  DEPTH   = 8
) (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   flush,
    input  logic   enq_valid,
    output logic   enq_ready,
    input  entry_t enq_data,
    output logic   deq_valid,
    input  logic   deq_ready,
    output entry_t deq_data
);
    localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_BITS = $clog2(DEPTH + 1);

    entry_t              mem [DEPTH];
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [CNT_BITS-1:0] count;
    logic                do_enq;
    logic                do_deq;

    // wrap at DEPTH, depth need not be a power of two
    function automatic logic [PTR_BITS-1:0] ptr_inc(input logic [PTR_BITS-1:0] p);
        return (p == PTR_BITS'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign enq_ready = (count != CNT_BITS'(DEPTH));  // full only
    assign deq_valid = (count != '0);
    assign deq_data  = mem[rd_ptr];                   // head stays put until taken

    assign do_enq = enq_valid && enq_ready;
    assign do_deq = deq_valid && deq_ready;

    always_ff @(posedge clk) begin
        if (do_enq)
            mem[wr_ptr] <= enq_data;
    end

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_enq)
                wr_ptr <= ptr_inc(wr_ptr);
            if (do_deq)
                rd_ptr <= ptr_inc(rd_ptr);
            case ({do_enq, do_deq})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;        // none, or one in one out
            endcase
        end
    end

endmodule

/* rtl/predicted_npc.sv */
// static next pc for one rv32 instruction
// backward branch taken, forward branch not taken, jal taken
module predicted_npc (
    input  fetch_pkg::instr_t instr,
    input  fetch_pkg::addr_t  pc,
    output logic              is_cond_br,
    output logic              br_dir_pred,
    output fetch_pkg::addr_t  next_pc
);
    import fetch_pkg::*;

    opcode_t opcode;
    addr_t   b_imm;       // sign extended branch offset
    addr_t   j_imm;       // sign extended jal offset
    addr_t   seq_pc;
    logic    is_jal;

    assign opcode = instr[6:0];

    // b-type imm[12|10:5|4:1|11]
    assign b_imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};

    // j-type imm[20|10:1|11|19:12]
    assign j_imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

    assign is_cond_br = (opcode == OPC_BRANCH);
    assign is_jal     = (opcode == OPC_JAL);

    // negative offset means backward, likely a loop
    assign br_dir_pred = is_cond_br && b_imm[ADDR_BITS-1];

    assign seq_pc = pc + addr_t'(INSTR_BYTES);

    always_comb begin
        if (is_jal)
            next_pc = pc + j_imm;
        else if (br_dir_pred)
            next_pc = pc + b_imm;
        else
            next_pc = seq_pc;  // forward branch or anything else
    end

endmodule

/* rtl/icache.sv */
// set associative icache, synchronous read
// rd_addr is sampled on the clock, hit/rd_block refer to that address one cycle later
// single outstanding miss, refill straight from the response
module icache #(
    parameter int NUM_SETS = mem_pkg::DEFAULT_NUM_SETS,
    parameter int NUM_WAYS = mem_pkg::DEFAULT_NUM_WAYS
) (
    input  logic               clk,
    input  logic               rst_n,
    input  fetch_pkg::addr_t   rd_addr,
    input  logic               mem_req_ready,
    input  logic               mem_resp_valid,
    input  mem_pkg::mem_resp_t mem_resp,
    output logic               hit,
    output mem_pkg::block_t    rd_block,
    output logic               mem_req_valid,
    output mem_pkg::mem_req_t  mem_req
);
    import mem_pkg::*;
    import fetch_pkg::*;

    localparam int OFF_BITS = $clog2(BLOCK_BITS / 8);
    localparam int IDX_BITS = $clog2(NUM_SETS);
    localparam int TAG_BITS = ADDR_BITS - IDX_BITS - OFF_BITS;
    localparam int WAY_BITS = (NUM_WAYS > 1) ? $clog2(NUM_WAYS) : 1;

    // address split for lookup
    typedef struct packed {
        logic [TAG_BITS-1:0] tag;
        logic [IDX_BITS-1:0] idx;
        logic [OFF_BITS-1:0] off;
    } split_addr_t;

    typedef enum logic {
        IDLE,
        WAITING
    } state_t;

    // storage
    logic [TAG_BITS-1:0] tag_arr   [NUM_SETS][NUM_WAYS];
    block_t              data_arr  [NUM_SETS][NUM_WAYS];
    logic [NUM_WAYS-1:0] valid_arr [NUM_SETS];
    logic [WAY_BITS-1:0] victim    [NUM_SETS];    // round robin per set

    // read port registers
    split_addr_t         rd_split;
    split_addr_t         req_q;                   // address the outputs belong to
    logic [TAG_BITS-1:0] tag_q [NUM_WAYS];
    block_t              data_q [NUM_WAYS];
    logic [NUM_WAYS-1:0] valid_q;

    logic [NUM_WAYS-1:0] way_hit;
    logic                hit_raw;                 // tag match, ignores fsm state

    // miss handling
    state_t              state;
    logic                req_done;                // request accepted, awaiting block
    split_addr_t         miss_q;                  // block aligned miss address
    logic                refill;
    logic [WAY_BITS-1:0] fill_way;

    assign rd_split = rd_addr;
    assign refill   = (state == WAITING) && mem_resp_valid;
    assign fill_way = victim[miss_q.idx];

    always_ff @(posedge clk) begin
        if (refill) begin
            tag_arr[miss_q.idx][fill_way]  <= miss_q.tag;
            data_arr[miss_q.idx][fill_way] <= mem_resp.data;
        end
    end

    // valid bits and victim pointers
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                valid_arr[s] <= '0;
                victim[s]    <= '0;
            end
        end else if (refill) begin
            valid_arr[miss_q.idx][fill_way] <= 1'b1;
            victim[miss_q.idx] <= (fill_way == WAY_BITS'(NUM_WAYS - 1)) ? '0
                                                                        : fill_way + 1'b1;
        end
    end

    // sync read, refill data forwarded when it lands on the set being read
    always_ff @(posedge clk) begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (refill && fill_way == WAY_BITS'(w) && miss_q.idx == rd_split.idx) begin
                tag_q[w]  <= miss_q.tag;
                data_q[w] <= mem_resp.data;
            end else begin
                tag_q[w]  <= tag_arr[rd_split.idx][w];
                data_q[w] <= data_arr[rd_split.idx][w];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= '0;
            req_q   <= RESET_PC;     // tracks the pc register
        end else begin
            valid_q <= valid_arr[rd_split.idx];
            if (refill && miss_q.idx == rd_split.idx)
                valid_q[fill_way] <= 1'b1;  // same-edge fill
            req_q <= rd_split;
        end
    end

    // tag compare, at most one way matches
    always_comb begin
        way_hit  = '0;
        rd_block = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            way_hit[w] = valid_q[w] && (tag_q[w] == req_q.tag);
            if (way_hit[w])
                rd_block = data_q[w];
        end
    end

    assign hit_raw = |way_hit;
    assign hit     = hit_raw && (state == IDLE);  // nothing usable while a miss is open

    // miss fsm
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= IDLE;
            req_done <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (!hit_raw) begin
                        state    <= WAITING;
                        req_done <= 1'b0;
                    end
                end
                WAITING: begin
                    if (mem_req_valid && mem_req_ready)
                        req_done <= 1'b1;
                    if (mem_resp_valid)
                        state <= IDLE;      // hit follows next cycle
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && !hit_raw) begin
            miss_q     <= req_q;
            miss_q.off <= '0;               // whole block
        end
    end

    assign mem_req_valid = (state == WAITING) && !req_done;
    assign mem_req.addr  = miss_q;          // held until accepted

endmodule

/* rtl/fetch_pkg.sv */
// instruction side of the fetch unit
package fetch_pkg;

    localparam int ADDR_BITS   = 32;
    localparam int INSTR_BITS  = 32;
    localparam int INSTR_BYTES = INSTR_BITS / 8;  // sequential pc step

    typedef logic [ADDR_BITS-1:0]  addr_t;
    typedef logic [INSTR_BITS-1:0] instr_t;
    typedef logic [6:0]            opcode_t;   // instr[6:0]

    localparam addr_t RESET_PC = 32'h0;        // first fetch after reset

    // rv32 base opcodes seen by the static predictor
    localparam opcode_t OPC_BRANCH = 7'b110_0011;  // beq/bne/blt/bge/bltu/bgeu
    localparam opcode_t OPC_JAL    = 7'b110_1111;

    // one instruction fifo slot, 98 bits
    // br_target_pred is whatever pc fetch went to next
    typedef struct packed {
        instr_t instr;
        addr_t  pc;
        logic   is_cond_br;     // b-type opcode
        logic   br_dir_pred;    // predicted taken
        addr_t  br_target_pred; // predicted next pc
    } ififo_entry_t;

endpackage

/* rtl/mem_pkg.sv */
// memory side of the fetch unit
// cache geometry and the block request/response channel
package mem_pkg;

    localparam int MEM_ADDR_BITS = 32;        // byte address on the memory bus
    localparam int BLOCK_BITS    = 64;        // two rv32 instructions per block

    // geometry the top level falls back to
    localparam int DEFAULT_NUM_SETS = 16;
    localparam int DEFAULT_NUM_WAYS = 2;

    typedef logic [BLOCK_BITS-1:0] block_t;   // one cache block, low word at lower address

    // block request, addr always block aligned
    typedef struct packed {
        logic [MEM_ADDR_BITS-1:0] addr;
    } mem_req_t;

    // block response, one cycle, no ready
    typedef struct packed {
        block_t data;
    } mem_resp_t;

endpackage
